/* verilog.f */
+incdir+include
verilog/wave_pkg.sv
verilog/wave_ctrl_regs.sv
verilog/wave_buffer.sv
verilog/wave_combiner.sv
verilog/wave_player.sv
bench/wave_player_asserts.sv
bench/wave_player_tb.sv

/* bench/wave_player_tb.sv */
`timescale 1ns/1ns
`include "wave_macros.svh"

module wave_player_tb;

localparam int MAX_CYCLES = 4000;
localparam int SAMPLES    = 1 << `WAVE_ADDR_BITS;
localparam logic [15:0] EXTREMES [4] = '{16'h7000, 16'h8800, 16'h7fff, 16'h8000};

logic              pipe_clk;
logic              reset;
logic [3:0]        awaddr;
logic              awvalid;
logic              awready;
logic [31:0]       wdata;
logic              wvalid;
logic              wready;
logic              bvalid;
logic              bready;
logic [1:0]        bresp;
logic [3:0]        araddr;
logic              arvalid;
logic              arready;
logic              rvalid;
logic              rready;
logic [31:0]       rdata;
logic [1:0]        rresp;
logic              pipe_in_write;
wave_pkg::sample_t pipe_in_data;
logic              pop_en;
wave_pkg::word_t   wave;
logic              wave_valid;

// Reference model state
logic [15:0]       ref_mem [2][SAMPLES];
int                ref_fill [2];
int                ref_rd;
logic              m_play;
logic [1:0]        m_mode;
int                m_len;
logic [31:0]       exp_q [$];
logic [31:0]       exp_word;
logic [31:0]       rd_val;
int                cycles;

wave_player i_wave_player (.*);

initial begin
    pipe_clk = 1'b0;
end

always #5 pipe_clk = ~pipe_clk;

////////////////////
// Helpers

task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "Run stopped on first error");
endtask

task automatic tick();
    @(posedge pipe_clk);
    #1;
endtask

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (actual === expected) else begin
        stop_with_error($sformatf("Fail %s expected %h actual %h", name, expected, actual));
    end
endtask

// Signed lane sum, clamped to 16 bits
function automatic logic [15:0] sat_lane(input logic [15:0] a, input logic [15:0] b);
    int sum;
    sum = int'($signed(a)) + int'($signed(b));
    if (sum > 32767) begin
        return 16'h7fff;
    end
    if (sum < -32768) begin
        return 16'h8000;
    end
    return 16'(sum);
endfunction

////////////////////
// AXI4-Lite

task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge pipe_clk);
    while (!awready) begin
        @(negedge pipe_clk);
    end
    check_value("wready", 32'd1, wready);
    tick();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    // Leave the response waiting a cycle
    tick();
    bready = 1'b1;
    @(negedge pipe_clk);
    while (!bvalid) begin
        @(negedge pipe_clk);
    end
    check_value("bresp", 32'd0, bresp);
    tick();
    bready = 1'b0;
endtask

task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge pipe_clk);
    while (!arready) begin
        @(negedge pipe_clk);
    end
    tick();
    arvalid = 1'b0;
    tick();
    rready = 1'b1;
    @(negedge pipe_clk);
    while (!rvalid) begin
        @(negedge pipe_clk);
    end
    check_value("rresp", 32'd0, rresp);
    data = rdata;
    tick();
    rready = 1'b0;
endtask

task automatic set_ctrl(input logic play, input logic ch, input logic [1:0] mode,
                        input logic clr);
    logic [31:0] value;
    value = '0;
    value[`CTRL_PLAY] = play;
    value[`CTRL_WR_CH] = ch;
    value[`CTRL_MODE_LO +: 2] = mode;
    value[`CTRL_CLEAR] = clr;
    axi_write(`REG_CTRL, value);
    m_play = play;
    m_mode = mode;
    if (clr) begin
        ref_fill[0] = 0;
        ref_fill[1] = 0;
        ref_rd = 0;
    end
endtask

////////////////////
// Pipe and playback

task automatic load_channel(input logic ch, input int count, input logic extremes);
    logic [15:0] sample;
    set_ctrl(1'b0, ch, m_mode, 1'b0);
    for (int i = 0; i < count; i++) begin
        sample = 16'($urandom());
        if (extremes && i < 4) begin
            sample = EXTREMES[i];
        end
        pipe_in_write = 1'b1;
        pipe_in_data = sample;
        ref_mem[ch][ref_fill[ch]] = sample;
        ref_fill[ch] = (ref_fill[ch] + 1) % SAMPLES;
        tick();
    end
    pipe_in_write = 1'b0;
endtask

task automatic push_expected();
    logic [31:0] w0;
    logic [31:0] w1;
    int last;
    w0 = {ref_mem[0][2*ref_rd+1], ref_mem[0][2*ref_rd]};
    w1 = {ref_mem[1][2*ref_rd+1], ref_mem[1][2*ref_rd]};
    case (m_mode)
        wave_pkg::MODE_CH0: exp_q.push_back(w0);
        wave_pkg::MODE_CH1: exp_q.push_back(w1);
        wave_pkg::MODE_SUM: begin
            exp_q.push_back({sat_lane(w0[31:16], w1[31:16]), sat_lane(w0[15:0], w1[15:0])});
        end
        default: exp_q.push_back('0);
    endcase
    last = (m_len == 0) ? (SAMPLES / 2 - 1) : (m_len - 1);
    ref_rd = (ref_rd == last) ? 0 : ref_rd + 1;
endtask

// Back-to-back pops, then two cycles of latency to drain
task automatic pop_words(input int count);
    for (int i = 0; i < count; i++) begin
        pop_en = 1'b1;
        if (m_play) begin
            push_expected();
        end
        tick();
    end
    pop_en = 1'b0;
    repeat (2) tick();
    while (exp_q.size() != 0) begin
        tick();
    end
endtask

////////////////////
// Monitors

always @(negedge pipe_clk) begin
    if (!reset && wave_valid) begin
        assert (exp_q.size() != 0) else begin
            stop_with_error("wave_valid rose with no pop pending");
        end
        if (exp_q.size() != 0) begin
            exp_word = exp_q.pop_front();
            check_value("wave", exp_word, wave);
        end
    end
end

always @(negedge pipe_clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
        stop_with_error($sformatf("Run timed out after %0d cycles", MAX_CYCLES));
    end
    if (i_wave_player.i_wave_player_asserts.assert_failed) begin
        stop_with_error("A bound timing assertion failed");
    end
end

////////////////////
// Test sequence

initial begin
    void'($urandom(32'had4b_6ba3));
    cycles = 0;
    reset = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    pipe_in_write = 1'b0;
    pipe_in_data = '0;
    pop_en = 1'b0;
    ref_fill[0] = 0;
    ref_fill[1] = 0;
    ref_rd = 0;
    m_play = 1'b0;
    m_mode = wave_pkg::MODE_CH0;
    m_len = 0;
    repeat (3) @(posedge pipe_clk);
    #1;
    reset = 1'b0;
    tick();
    check_value("wave_valid", 32'd0, wave_valid);
    check_value("wave", 32'd0, wave);
    check_value("bvalid", 32'd0, bvalid);
    check_value("rvalid", 32'd0, rvalid);

    // Register access, CTRL with wr_channel 1 and mode 2 reads 0xA
    set_ctrl(1'b0, 1'b1, wave_pkg::MODE_SUM, 1'b0);
    axi_read(`REG_CTRL, rd_val);
    check_value("CTRL", 32'h0000_000a, rd_val);
    axi_write(`REG_LENGTH, 32'd3);
    m_len = 3;
    axi_read(`REG_LENGTH, rd_val);
    check_value("LENGTH", 32'd3, rd_val);
    axi_read(4'hc, rd_val);
    check_value("unmapped", 32'd0, rd_val);
    // Read held while a write arrives, so it must see the new length
    araddr = `REG_LENGTH;
    arvalid = 1'b1;
    axi_write(`REG_LENGTH, 32'd8);
    m_len = 8;
    axi_read(`REG_LENGTH, rd_val);
    check_value("LENGTH", 32'd8, rd_val);

    // Pipe load and fill levels
    load_channel(1'b0, 20, 1'b0);
    load_channel(1'b1, 33, 1'b0);
    axi_read(`REG_STATUS, rd_val);
    check_value("STATUS", {16'd33, 16'd20}, rd_val);

    // Per channel playback across the loop wrap
    set_ctrl(1'b1, 1'b0, wave_pkg::MODE_CH0, 1'b0);
    pop_words(10);
    pop_words(1);
    pop_words(1);
    set_ctrl(1'b1, 1'b1, wave_pkg::MODE_CH1, 1'b0);
    pop_words(10);
    set_ctrl(1'b0, 1'b1, wave_pkg::MODE_CH1, 1'b0);
    pop_words(4);

    // Clear, then saturating sum from word 0
    set_ctrl(1'b0, 1'b0, wave_pkg::MODE_CH0, 1'b1);
    axi_read(`REG_STATUS, rd_val);
    check_value("STATUS", 32'd0, rd_val);
    load_channel(1'b0, 16, 1'b1);
    load_channel(1'b1, 16, 1'b1);
    set_ctrl(1'b1, 1'b0, wave_pkg::MODE_SUM, 1'b0);
    pop_words(8);
    set_ctrl(1'b1, 1'b0, wave_pkg::MODE_MUTE, 1'b0);
    pop_words(3);

    repeat (4) tick();
    if (i_wave_player.i_wave_player_asserts.assert_failed) begin
        stop_with_error("A bound timing assertion failed");
    end else begin
        $display("Finished with no errors");
        $finish;
    end
end

endmodule

/* bench/wave_player_asserts.sv */
`timescale 1ns/1ns

module wave_player_asserts (
    input logic        pipe_clk,
    input logic        reset,
    input logic        pop_en,
    input logic        play,
    input logic        wave_valid,
    input logic        bvalid,
    input logic        bready,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata
);

logic assert_failed = 1'b0;

////////////////////
// Playback latency

// Fetch at k, combiner result at k+2
a_pop_to_valid: assert property (@(posedge pipe_clk) disable iff (reset)
    (pop_en && play) |-> ##2 wave_valid)
    else begin
        assert_failed = 1'b1;
        $error("wave_valid missing two cycles after a pop with play high");
    end

// Covers play low as well
a_valid_has_pop: assert property (@(posedge pipe_clk) disable iff (reset)
    wave_valid |-> $past(pop_en && play, 2))
    else begin
        assert_failed = 1'b1;
        $error("wave_valid without a pop with play high two cycles earlier");
    end

////////////////////
// AXI response hold

a_bvalid_hold: assert property (@(posedge pipe_clk) disable iff (reset)
    (bvalid && !bready) |=> bvalid)
    else begin
        assert_failed = 1'b1;
        $error("bvalid dropped before bready");
    end

a_rvalid_hold: assert property (@(posedge pipe_clk) disable iff (reset)
    (rvalid && !rready) |=> (rvalid && $stable(rdata)))
    else begin
        assert_failed = 1'b1;
        $error("rvalid or rdata changed before rready");
    end

endmodule

bind wave_player wave_player_asserts i_wave_player_asserts (
    .pipe_clk   (pipe_clk),
    .reset      (reset),
    .pop_en     (pop_en),
    .play       (play),
    .wave_valid (wave_valid),
    .bvalid     (bvalid),
    .bready     (bready),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata)
);

/* verilog/wave_player.sv */
`timescale 1ns/1ns

module wave_player (
    input  logic              pipe_clk,
    input  logic              reset,
    // AXI4-Lite register port
    input  logic [3:0]        awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [31:0]       wdata,
    input  logic              wvalid,
    output logic              wready,
    output logic              bvalid,
    input  logic              bready,
    output logic [1:0]        bresp,
    input  logic [3:0]        araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic              rvalid,
    input  logic              rready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp,
    // Host pipe
    input  logic              pipe_in_write,
    input  wave_pkg::sample_t pipe_in_data,
    // Playback
    input  logic              pop_en,
    output wave_pkg::word_t   wave,
    output logic              wave_valid
);

logic                   play;
logic                   wr_channel;
wave_pkg::mode_t        mode;
wave_pkg::word_addr_t   loop_len;
logic                   clear;
wave_pkg::sample_addr_t fill0;
wave_pkg::sample_addr_t fill1;
logic                   wr_en0;
logic                   wr_en1;
wave_pkg::word_t        word0;
wave_pkg::word_t        word1;
logic                   word_valid;

// Pipe writes go to the selected channel only
assign wr_en0 = pipe_in_write && (wr_channel == 1'b0);
assign wr_en1 = pipe_in_write && (wr_channel == 1'b1);

wave_ctrl_regs i_wave_ctrl_regs (
    .pipe_clk   (pipe_clk),
    .reset      (reset),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wvalid     (wvalid),
    .wready     (wready),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .fill0      (fill0),
    .fill1      (fill1),
    .play       (play),
    .wr_channel (wr_channel),
    .mode       (mode),
    .loop_len   (loop_len),
    .clear      (clear)
);

wave_buffer buf0 (
    .pipe_clk (pipe_clk),
    .reset    (reset),
    .clear    (clear),
    .wr_en    (wr_en0),
    .wr_data  (pipe_in_data),
    .pop_en   (pop_en),
    .play     (play),
    .loop_len (loop_len),
    .rd_word  (word0),
    .rd_valid (word_valid),
    .fill     (fill0)
);

// Same pop_en and play as buf0, so its valid is redundant
wave_buffer buf1 (
    .pipe_clk (pipe_clk),
    .reset    (reset),
    .clear    (clear),
    .wr_en    (wr_en1),
    .wr_data  (pipe_in_data),
    .pop_en   (pop_en),
    .play     (play),
    .loop_len (loop_len),
    .rd_word  (word1),
    .rd_valid (),
    .fill     (fill1)
);

wave_combiner i_wave_combiner (
    .pipe_clk   (pipe_clk),
    .reset      (reset),
    .word0      (word0),
    .word1      (word1),
    .valid_in   (word_valid),
    .mode       (mode),
    .wave       (wave),
    .wave_valid (wave_valid)
);

endmodule

/* verilog/wave_combiner.sv */
`timescale 1ns/1ns

module wave_combiner (
    input  logic            pipe_clk,
    input  logic            reset,
    input  wave_pkg::word_t word0,
    input  wave_pkg::word_t word1,
    input  logic            valid_in,
    input  wave_pkg::mode_t mode,
    output wave_pkg::word_t wave,
    output logic            wave_valid
);

wave_pkg::word_t result;

// Signed add clamped to the 16-bit range
function automatic wave_pkg::sample_t sat_add(
    input wave_pkg::sample_t a,
    input wave_pkg::sample_t b
);
    logic signed [16:0] sum;
    sum = a + b;
    // Top two bits differ only on overflow
    if (sum[16] != sum[15]) begin
        return sum[16] ? 16'sh8000 : 16'sh7fff;
    end
    return sum[15:0];
endfunction

////////////////////
// Lane select

always_comb begin
    case (mode)
        wave_pkg::MODE_CH0: begin
            result = word0;
        end
        wave_pkg::MODE_CH1: begin
            result = word1;
        end
        wave_pkg::MODE_SUM: begin
            result[15:0]  = sat_add(word0[15:0], word1[15:0]);
            result[31:16] = sat_add(word0[31:16], word1[31:16]);
        end
        wave_pkg::MODE_MUTE: begin
            result = '0;
        end
        default: begin
            result = '0;
        end
    endcase
end

// Output register, one cycle behind the buffers
always_ff @(posedge pipe_clk) begin
    if (reset) begin
        wave       <= '0;
        wave_valid <= 1'b0;
    end else begin
        wave_valid <= valid_in;
        if (valid_in) begin
            wave <= result;
        end
    end
end

endmodule

/* verilog/wave_buffer.sv */
`timescale 1ns/1ns
`include "wave_macros.svh"

module wave_buffer (
    input  logic                   pipe_clk,
    input  logic                   reset,
    input  logic                   clear,
    input  logic                   wr_en,
    input  wave_pkg::sample_t      wr_data,
    input  logic                   pop_en,
    input  logic                   play,
    input  wave_pkg::word_addr_t   loop_len,
    output wave_pkg::word_t        rd_word,
    output logic                   rd_valid,
    output wave_pkg::sample_addr_t fill
);

localparam int WORDS = 1 << `WAVE_WORD_ADDR_BITS;

// Even samples in one bank, odd in the other, so a word is one read of each
wave_pkg::sample_t      mem_even [WORDS];
wave_pkg::sample_t      mem_odd  [WORDS];

wave_pkg::sample_addr_t wr_ptr;
wave_pkg::word_addr_t   rd_ptr;
wave_pkg::word_addr_t   last_word;
logic                   fetch;

assign fill  = wr_ptr;
assign fetch = pop_en && play;

// Length 0 underflows to the top word, giving the full buffer
assign last_word = loop_len - 1'b1;

////////////////////
// Pipe side

always_ff @(posedge pipe_clk) begin
    if (wr_en) begin
        if (wr_ptr[0]) begin
            mem_odd[wr_ptr[`WAVE_ADDR_BITS-1:1]] <= wr_data;
        end else begin
            mem_even[wr_ptr[`WAVE_ADDR_BITS-1:1]] <= wr_data;
        end
    end
end

// Wraps past the last address, no back-pressure
always_ff @(posedge pipe_clk) begin
    if (reset || clear) begin
        wr_ptr <= '0;
    end else if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
    end
end

////////////////////
// Playback side

always_ff @(posedge pipe_clk) begin
    if (fetch) begin
        rd_word <= {mem_odd[rd_ptr], mem_even[rd_ptr]};
    end
end

always_ff @(posedge pipe_clk) begin
    if (reset) begin
        rd_ptr   <= '0;
        rd_valid <= 1'b0;
    end else begin
        rd_valid <= fetch;
        if (clear) begin
            rd_ptr <= '0;
        end else if (fetch) begin
            if (rd_ptr == last_word) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end
end

endmodule

/* verilog/wave_ctrl_regs.sv */
`timescale 1ns/1ns
`include "wave_macros.svh"

module wave_ctrl_regs (
    input  logic                   pipe_clk,
    input  logic                   reset,
    // AXI4-Lite write side
    input  logic [3:0]             awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic                   bvalid,
    input  logic                   bready,
    output logic [1:0]             bresp,
    // AXI4-Lite read side
    input  logic [3:0]             araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp,
    // Buffer status
    input  wave_pkg::sample_addr_t fill0,
    input  wave_pkg::sample_addr_t fill1,
    // Player control
    output logic                   play,
    output logic                   wr_channel,
    output wave_pkg::mode_t        mode,
    output wave_pkg::word_addr_t   loop_len,
    output logic                   clear
);

wave_pkg::axi_state_t state;
logic                 wr_take;
logic                 rd_take;
logic [31:0]          rd_mux;

////////////////////
// Handshake

// Write needs address and data together, and beats a read
assign wr_take = (state == wave_pkg::AXI_IDLE) && awvalid && wvalid;
assign rd_take = (state == wave_pkg::AXI_IDLE) && arvalid && !(awvalid && wvalid);

assign awready = wr_take;
assign wready  = wr_take;
assign arready = rd_take;

assign bvalid = (state == wave_pkg::AXI_WRESP);
assign rvalid = (state == wave_pkg::AXI_RDATA);

// Always OKAY
assign bresp = 2'b00;
assign rresp = 2'b00;

always_ff @(posedge pipe_clk) begin
    if (reset) begin
        state <= wave_pkg::AXI_IDLE;
    end else begin
        case (state)
            wave_pkg::AXI_IDLE: begin
                if (wr_take) begin
                    state <= wave_pkg::AXI_WRESP;
                end else if (rd_take) begin
                    state <= wave_pkg::AXI_RDATA;
                end
            end
            wave_pkg::AXI_WRESP: begin
                if (bready) begin
                    state <= wave_pkg::AXI_IDLE;
                end
            end
            wave_pkg::AXI_RDATA: begin
                if (rready) begin
                    state <= wave_pkg::AXI_IDLE;
                end
            end
            default: begin
                state <= wave_pkg::AXI_IDLE;
            end
        endcase
    end
end

////////////////////
// Registers

always_ff @(posedge pipe_clk) begin
    if (reset) begin
        play       <= 1'b0;
        wr_channel <= 1'b0;
        mode       <= wave_pkg::MODE_CH0;
        loop_len   <= '0;
        clear      <= 1'b0;
    end else begin
        // Clear is a pulse, never stored
        clear <= 1'b0;
        if (wr_take) begin
            case (awaddr)
                `REG_CTRL: begin
                    play       <= wdata[`CTRL_PLAY];
                    wr_channel <= wdata[`CTRL_WR_CH];
                    mode       <= wave_pkg::mode_t'(wdata[`CTRL_MODE_LO +: 2]);
                    clear      <= wdata[`CTRL_CLEAR];
                end
                `REG_LENGTH: begin
                    loop_len <= wdata[`WAVE_WORD_ADDR_BITS-1:0];
                end
                default: begin
                end
            endcase
        end
    end
end

////////////////////
// Read data

always_comb begin
    rd_mux = '0;
    case (araddr)
        `REG_CTRL: begin
            rd_mux[`CTRL_PLAY]          = play;
            rd_mux[`CTRL_WR_CH]         = wr_channel;
            rd_mux[`CTRL_MODE_LO +: 2]  = mode;
        end
        `REG_LENGTH: begin
            rd_mux[`WAVE_WORD_ADDR_BITS-1:0] = loop_len;
        end
        // Write pointers, channel 1 in the upper half
        `REG_STATUS: begin
            rd_mux[`WAVE_ADDR_BITS-1:0] = fill0;
            rd_mux[16 +: `WAVE_ADDR_BITS] = fill1;
        end
        default: begin
        end
    endcase
end

always_ff @(posedge pipe_clk) begin
    if (rd_take) begin
        rdata <= rd_mux;
    end
end

endmodule

/* verilog/wave_pkg.sv */
`include "wave_macros.svh"

package wave_pkg;

    // One signed sample and the word that packs two of them
    typedef logic signed [15:0] sample_t;
    typedef logic [31:0] word_t;

    typedef logic [`WAVE_ADDR_BITS-1:0] sample_addr_t;
    typedef logic [`WAVE_WORD_ADDR_BITS-1:0] word_addr_t;

    typedef enum logic [1:0] {
        MODE_CH0  = 2'd0,
        MODE_CH1  = 2'd1,
        MODE_SUM  = 2'd2,
        MODE_MUTE = 2'd3
    } mode_t;

    typedef enum logic [1:0] {
        AXI_IDLE,
        AXI_WRESP,
        AXI_RDATA
    } axi_state_t;

endpackage

/* include/wave_macros.svh */
`ifndef WAVE_MACROS_SVH
`define WAVE_MACROS_SVH

// Buffer geometry, 256 samples or 128 words per channel
`define WAVE_ADDR_BITS      8
`define WAVE_WORD_ADDR_BITS (`WAVE_ADDR_BITS - 1)

// Register byte offsets
`define REG_CTRL            4'h0
`define REG_LENGTH          4'h4
`define REG_STATUS          4'h8

// Control register fields
`define CTRL_PLAY           0
`define CTRL_WR_CH          1
`define CTRL_MODE_LO        2
`define CTRL_CLEAR          4

`endif
